// File: common/axil_pkg.sv
/* AXI4-Lite protocol definitions: bus widths, response codes and channel payload structs */

package axil_pkg;

    // Byte address and data widths of the slave ports
    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

    // Response codes, only the two this slave returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // Write address, 35 bits
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] addr;
        logic [2:0]             prot;
    } axil_aw_t;

    // Read address, same layout as AW
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] addr;
        logic [2:0]             prot;
    } axil_ar_t;

    // Write data with byte strobes, 36 bits
    typedef struct packed {
        logic [AXIL_DATA_W-1:0] data;
        logic [AXIL_STRB_W-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    // Read data plus response, 34 bits
    typedef struct packed {
        logic [AXIL_DATA_W-1:0] data;
        axil_resp_e             resp;
    } axil_r_t;

endpackage

// File: common/mem_pkg.sv
/* Internal memory bus: widths and the request and response structs between ports and arbiter */

package mem_pkg;

    // Word address of a 32-bit byte address
    localparam int MEM_WORD_ADDR_W = 30;
    localparam int MEM_DATA_W = 32;
    localparam int MEM_BE_W = MEM_DATA_W / 8;

    // Request from a port, 67 bits
    typedef struct packed {
        // High for a write, low for a read
        logic                       wr;
        logic [MEM_WORD_ADDR_W-1:0] addr;
        logic [MEM_DATA_W-1:0]      wdata;
        logic [MEM_BE_W-1:0]        be;
    } mem_req_t;

    // Response to the granted port, 33 bits
    typedef struct packed {
        logic [MEM_DATA_W-1:0] rdata;
        // Out-of-range address, becomes SLVERR at the port
        logic                  err;
    } mem_rsp_t;

endpackage

// File: src/ram.sv
/* Word RAM with byte-enable writes and a combinational or registered read port */
`timescale 1ns/1ns

module ram #(
    parameter int ADDR_WIDTH = 8,
    parameter int DATA_WIDTH = 32,
    parameter bit REG_OUT = 1'b0
) (
    input  logic                            aclk,
    input  logic                            wr_en,
    input  logic [(DATA_WIDTH + 7) / 8-1:0] be,
    input  logic [ADDR_WIDTH-1:0]           addr_in,
    input  logic [DATA_WIDTH-1:0]           data_in,
    input  logic [ADDR_WIDTH-1:0]           addr_out,
    output logic [DATA_WIDTH-1:0]           data_out
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // Each bit follows the enable of the byte lane it sits in
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            for (int i = 0; i < DATA_WIDTH; i++) begin
                if (be[i / 8]) begin
                    mem[addr_in][i] <= data_in[i];
                end
            end
        end
    end

    generate
        if (REG_OUT) begin : g_reg_out
            // Read data one cycle after the address
            always_ff @(posedge aclk) begin
                data_out <= mem[addr_out];
            end
        end else begin : g_comb_out
            assign data_out = mem[addr_out];
        end
    endgenerate

endmodule

// File: src/scfifo.sv
/* Single-clock FIFO with a typed payload, full/empty and almost flags,
   flush, soft reset and an optional pass-thru path for an empty FIFO */
`timescale 1ns/1ns

module scfifo #(
    parameter type payload_t = logic [7:0],
    parameter bit PASS_THRU = 1'b0,
    parameter int ADDR_WIDTH = 2
) (
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     srst,
    input  logic     flush,
    input  payload_t data_in,
    input  logic     push,
    output logic     full,
    output logic     afull,
    output payload_t data_out,
    input  logic     pull,
    output logic     empty,
    output logic     aempty
);

    localparam int DATA_WIDTH = $bits(payload_t);
    localparam int BE_WIDTH = (DATA_WIDTH + 7) / 8;

    // Pointers carry one extra wrap bit
    logic [ADDR_WIDTH:0]   wrptr;
    logic [ADDR_WIDTH:0]   rdptr;
    logic [ADDR_WIDTH:0]   ptr_diff;
    logic                  empty_flag;
    logic                  pass_thru;
    logic                  wr_en;
    logic [DATA_WIDTH-1:0] ram_rdata;

    //////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////

    // No write while bypassing or clearing
    assign wr_en = push & ~full & ~pass_thru & ~flush & ~srst;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wrptr <= '0;
            rdptr <= '0;
        end else if (srst || flush) begin
            wrptr <= '0;
            rdptr <= '0;
        end else begin
            if (wr_en) begin
                wrptr <= wrptr + 1'b1;
            end
            // Pull on an empty FIFO is ignored
            if (pull && !empty_flag) begin
                rdptr <= rdptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Flags
    //////////////////////////////////////////////////

    assign ptr_diff = wrptr - rdptr;
    assign empty_flag = (wrptr == rdptr);
    assign full = (ptr_diff == {1'b1, {ADDR_WIDTH{1'b0}}});
    // One slot left
    assign afull = (ptr_diff == {1'b0, {ADDR_WIDTH{1'b1}}});
    // One entry left
    assign aempty = (ptr_diff == (ADDR_WIDTH + 1)'(1));

    // Flat storage, every byte lane written
    ram #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .REG_OUT    (1'b0)
    ) u_ram (
        .aclk     (aclk),
        .wr_en    (wr_en),
        .be       ({BE_WIDTH{1'b1}}),
        .addr_in  (wrptr[ADDR_WIDTH-1:0]),
        .data_in  (data_in),
        .addr_out (rdptr[ADDR_WIDTH-1:0]),
        .data_out (ram_rdata)
    );

    //////////////////////////////////////////////////
    // Output path
    //////////////////////////////////////////////////

    generate
        if (PASS_THRU) begin : g_pass_thru
            // Consumer waiting on an empty FIFO takes the input directly
            assign pass_thru = (pull & empty_flag) | flush;
            assign data_out = pass_thru ? data_in : payload_t'(ram_rdata);
            assign empty = pass_thru ? ~push : empty_flag;
        end else begin : g_stored
            assign pass_thru = 1'b0;
            assign data_out = payload_t'(ram_rdata);
            assign empty = empty_flag;
        end
    endgenerate

endmodule

// File: axil_port/axil_port.sv
/* AXI4-Lite slave port: five channel FIFOs, read/write alternation with
   response credits, and routing of memory responses to B or R */
`timescale 1ns/1ns

module axil_port #(
    parameter int FIFO_ADDR_WIDTH = 2
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               flush,
    input  axil_pkg::axil_aw_t aw,
    input  logic               awvalid,
    output logic               awready,
    input  axil_pkg::axil_w_t  w,
    input  logic               wvalid,
    output logic               wready,
    output axil_pkg::axil_b_t  b,
    output logic               bvalid,
    input  logic               bready,
    input  axil_pkg::axil_ar_t ar,
    input  logic               arvalid,
    output logic               arready,
    output axil_pkg::axil_r_t  r,
    output logic               rvalid,
    input  logic               rready,
    output logic               req_valid,
    output mem_pkg::mem_req_t  req,
    input  logic               grant,
    input  logic               rsp_valid,
    input  mem_pkg::mem_rsp_t  rsp
);

    import axil_pkg::*;
    import mem_pkg::*;

    axil_aw_t   aw_q;
    axil_w_t    w_q;
    axil_ar_t   ar_q;
    axil_b_t    b_in;
    axil_r_t    r_in;
    axil_resp_e rsp_code;
    logic       aw_full;
    logic       aw_empty;
    logic       w_full;
    logic       w_empty;
    logic       ar_full;
    logic       ar_empty;
    logic       b_full;
    logic       b_afull;
    logic       b_empty;
    logic       r_full;
    logic       r_afull;
    logic       r_empty;
    logic       rd_ok;
    logic       wr_ok;
    logic       sel_rd;
    logic       prefer_rd;
    logic       pending_rd;
    logic       rd_pop;
    logic       wr_pop;
    logic       b_push;
    logic       r_push;

    //////////////////////////////////////////////////
    // Channel FIFOs
    //////////////////////////////////////////////////

    // Port flush only clears pointers, the bypass flush stays idle
    scfifo #(.payload_t(axil_aw_t), .ADDR_WIDTH(FIFO_ADDR_WIDTH)) u_aw_fifo (
        .aclk, .aresetn, .srst(flush), .flush(1'b0),
        .data_in(aw), .push(awvalid), .full(aw_full), .afull(),
        .data_out(aw_q), .pull(wr_pop), .empty(aw_empty), .aempty()
    );

    scfifo #(.payload_t(axil_w_t), .ADDR_WIDTH(FIFO_ADDR_WIDTH)) u_w_fifo (
        .aclk, .aresetn, .srst(flush), .flush(1'b0),
        .data_in(w), .push(wvalid), .full(w_full), .afull(),
        .data_out(w_q), .pull(wr_pop), .empty(w_empty), .aempty()
    );

    scfifo #(.payload_t(axil_ar_t), .ADDR_WIDTH(FIFO_ADDR_WIDTH)) u_ar_fifo (
        .aclk, .aresetn, .srst(flush), .flush(1'b0),
        .data_in(ar), .push(arvalid), .full(ar_full), .afull(),
        .data_out(ar_q), .pull(rd_pop), .empty(ar_empty), .aempty()
    );

    // Response FIFOs bypass when the master is already waiting
    // Pull is the ready itself since the FIFO ignores it when empty
    scfifo #(.payload_t(axil_b_t), .PASS_THRU(1'b1), .ADDR_WIDTH(FIFO_ADDR_WIDTH)) u_b_fifo (
        .aclk, .aresetn, .srst(flush), .flush(1'b0),
        .data_in(b_in), .push(b_push), .full(b_full), .afull(b_afull),
        .data_out(b), .pull(bready), .empty(b_empty), .aempty()
    );

    scfifo #(.payload_t(axil_r_t), .PASS_THRU(1'b1), .ADDR_WIDTH(FIFO_ADDR_WIDTH)) u_r_fifo (
        .aclk, .aresetn, .srst(flush), .flush(1'b0),
        .data_in(r_in), .push(r_push), .full(r_full), .afull(r_afull),
        .data_out(r), .pull(rready), .empty(r_empty), .aempty()
    );

    assign awready = ~aw_full;
    assign wready = ~w_full;
    assign arready = ~ar_full;
    assign bvalid = ~b_empty;
    assign rvalid = ~r_empty;

    //////////////////////////////////////////////////
    // Request side
    //////////////////////////////////////////////////

    // Keep a free slot for the response already in flight
    assign rd_ok = ~ar_empty & ~r_full & ~r_afull;
    assign wr_ok = ~aw_empty & ~w_empty & ~b_full & ~b_afull;
    // Toggle only matters when both kinds are eligible
    assign sel_rd = rd_ok & (~wr_ok | prefer_rd);

    assign req_valid = rd_ok | wr_ok;
    assign req.wr = ~sel_rd;
    assign req.addr = sel_rd ? ar_q.addr[AXIL_ADDR_W-1:2] : aw_q.addr[AXIL_ADDR_W-1:2];
    assign req.wdata = w_q.data;
    assign req.be = w_q.strb;

    assign rd_pop = grant & sel_rd;
    assign wr_pop = grant & ~sel_rd;

    // Remember the kind of the granted request for its response
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            prefer_rd <= 1'b0;
            pending_rd <= 1'b0;
        end else if (grant) begin
            prefer_rd <= ~prefer_rd;
            pending_rd <= sel_rd;
        end
    end

    //////////////////////////////////////////////////
    // Response side
    //////////////////////////////////////////////////

    assign rsp_code = rsp.err ? SLVERR : OKAY;
    assign b_in = '{resp: rsp_code};
    assign r_in = '{data: rsp.rdata, resp: rsp_code};
    assign b_push = rsp_valid & ~pending_rd;
    assign r_push = rsp_valid & pending_rd;

endmodule

// File: src/mem_arbiter.sv
/* Round-robin arbiter of two memory ports: drives the RAM, flags
   out-of-range addresses and returns the response a cycle after grant */
`timescale 1ns/1ns

module mem_arbiter #(
    parameter int MEM_ADDR_WIDTH = 10
) (
    input  logic                              aclk,
    input  logic                              aresetn,
    input  logic [1:0]                        req_valid,
    input  mem_pkg::mem_req_t [1:0]           req,
    output logic [1:0]                        grant,
    output logic [1:0]                        rsp_valid,
    output mem_pkg::mem_rsp_t                 rsp,
    output logic                              mem_wr_en,
    output logic [mem_pkg::MEM_BE_W-1:0]      mem_be,
    output logic [MEM_ADDR_WIDTH-1:0]         mem_addr,
    output logic [mem_pkg::MEM_DATA_W-1:0]    mem_wdata,
    input  logic [mem_pkg::MEM_DATA_W-1:0]    mem_rdata
);

    import mem_pkg::*;

    logic       sel;
    logic       range_err;
    // High when port 1 goes first
    logic       prio_p1;
    logic [1:0] grant_q;
    logic       err_q;

    // Port 0 wins unless port 1 also asks and holds priority
    always_comb begin
        grant = 2'b00;
        if (req_valid[0] && !(req_valid[1] && prio_p1)) begin
            grant[0] = 1'b1;
        end else if (req_valid[1]) begin
            grant[1] = 1'b1;
        end
    end

    assign sel = grant[1];

    // Word address bits above the RAM depth must be zero
    assign range_err = (req[sel].addr >> MEM_ADDR_WIDTH) != '0;

    assign mem_wr_en = (|grant) & req[sel].wr & ~range_err;
    assign mem_be = req[sel].be;
    assign mem_addr = req[sel].addr[MEM_ADDR_WIDTH-1:0];
    assign mem_wdata = req[sel].wdata;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            prio_p1 <= 1'b0;
            grant_q <= 2'b00;
            err_q <= 1'b0;
        end else begin
            grant_q <= grant;
            err_q <= range_err;
            // Priority moves to the port not just served
            if (|grant) begin
                prio_p1 <= grant[0];
            end
        end
    end

    // RAM read data is registered, aligned with grant_q
    assign rsp_valid = grant_q;
    assign rsp.rdata = err_q ? {MEM_DATA_W{1'b0}} : mem_rdata;
    assign rsp.err = err_q;

endmodule

// File: src/axil_mem_top.sv
/* Dual-port AXI4-Lite memory: two slave ports, the arbiter and the shared RAM */
`timescale 1ns/1ns

module axil_mem_top #(
    parameter int MEM_ADDR_WIDTH = 10,
    parameter int FIFO_ADDR_WIDTH = 2
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  axil_pkg::axil_aw_t s0_aw,
    input  logic               s0_awvalid,
    output logic               s0_awready,
    input  axil_pkg::axil_w_t  s0_w,
    input  logic               s0_wvalid,
    output logic               s0_wready,
    output axil_pkg::axil_b_t  s0_b,
    output logic               s0_bvalid,
    input  logic               s0_bready,
    input  axil_pkg::axil_ar_t s0_ar,
    input  logic               s0_arvalid,
    output logic               s0_arready,
    output axil_pkg::axil_r_t  s0_r,
    output logic               s0_rvalid,
    input  logic               s0_rready,
    input  axil_pkg::axil_aw_t s1_aw,
    input  logic               s1_awvalid,
    output logic               s1_awready,
    input  axil_pkg::axil_w_t  s1_w,
    input  logic               s1_wvalid,
    output logic               s1_wready,
    output axil_pkg::axil_b_t  s1_b,
    output logic               s1_bvalid,
    input  logic               s1_bready,
    input  axil_pkg::axil_ar_t s1_ar,
    input  logic               s1_arvalid,
    output logic               s1_arready,
    output axil_pkg::axil_r_t  s1_r,
    output logic               s1_rvalid,
    input  logic               s1_rready
);

    import mem_pkg::*;

    mem_req_t [1:0]            req;
    mem_rsp_t                  rsp;
    logic [1:0]                req_valid;
    logic [1:0]                grant;
    logic [1:0]                rsp_valid;
    logic                      mem_wr_en;
    logic [MEM_BE_W-1:0]       mem_be;
    logic [MEM_ADDR_WIDTH-1:0] mem_addr;
    logic [MEM_DATA_W-1:0]     mem_wdata;
    logic [MEM_DATA_W-1:0]     mem_rdata;

    // Port 0, typically the instruction side
    axil_port #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) u_port0 (
        .aclk, .aresetn, .flush(1'b0),
        .aw(s0_aw), .awvalid(s0_awvalid), .awready(s0_awready),
        .w(s0_w), .wvalid(s0_wvalid), .wready(s0_wready),
        .b(s0_b), .bvalid(s0_bvalid), .bready(s0_bready),
        .ar(s0_ar), .arvalid(s0_arvalid), .arready(s0_arready),
        .r(s0_r), .rvalid(s0_rvalid), .rready(s0_rready),
        .req_valid(req_valid[0]), .req(req[0]),
        .grant(grant[0]), .rsp_valid(rsp_valid[0]), .rsp(rsp)
    );

    // Port 1, typically the data side
    axil_port #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) u_port1 (
        .aclk, .aresetn, .flush(1'b0),
        .aw(s1_aw), .awvalid(s1_awvalid), .awready(s1_awready),
        .w(s1_w), .wvalid(s1_wvalid), .wready(s1_wready),
        .b(s1_b), .bvalid(s1_bvalid), .bready(s1_bready),
        .ar(s1_ar), .arvalid(s1_arvalid), .arready(s1_arready),
        .r(s1_r), .rvalid(s1_rvalid), .rready(s1_rready),
        .req_valid(req_valid[1]), .req(req[1]),
        .grant(grant[1]), .rsp_valid(rsp_valid[1]), .rsp(rsp)
    );

    mem_arbiter #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_arbiter (
        .aclk, .aresetn,
        .req_valid, .req, .grant, .rsp_valid, .rsp,
        .mem_wr_en, .mem_be, .mem_addr, .mem_wdata, .mem_rdata
    );

    // Shared word RAM, read and write on the same address
    ram #(
        .ADDR_WIDTH (MEM_ADDR_WIDTH),
        .DATA_WIDTH (MEM_DATA_W),
        .REG_OUT    (1'b1)
    ) u_ram (
        .aclk     (aclk),
        .wr_en    (mem_wr_en),
        .be       (mem_be),
        .addr_in  (mem_addr),
        .data_in  (mem_wdata),
        .addr_out (mem_addr),
        .data_out (mem_rdata)
    );

endmodule

// File: tests/tb_clock.sv
/* Testbench clock and reset source */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2) aclk = ~aclk;
    end

    // Release away from the rising edge
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
    end

endmodule

// File: tests/axil_mem_checker.sv
/* Response checker for both AXI4-Lite ports: queues expected responses at the
   address handshake and compares them at the B and R handshakes */
`timescale 1ns/1ns

module axil_mem_checker (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic [1:0]              awvalid,
    input  logic [1:0]              awready,
    input  logic [1:0]              arvalid,
    input  logic [1:0]              arready,
    input  axil_pkg::axil_b_t [1:0] b,
    input  logic [1:0]              bvalid,
    input  logic [1:0]              bready,
    input  axil_pkg::axil_r_t [1:0] r,
    input  logic [1:0]              rvalid,
    input  logic [1:0]              rready,
    input  axil_pkg::axil_b_t [1:0] exp_b,
    input  axil_pkg::axil_r_t [1:0] exp_r,
    output int                      errors,
    output int                      checks
);

    import axil_pkg::*;

    // Outstanding expectations, one queue per port and channel
    axil_b_t b_q [2][$];
    axil_r_t r_q [2][$];
    axil_b_t exp_bv;
    axil_r_t exp_rv;

    task automatic compare(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s expected %h got %h", name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // Sampling on the handshake edge
    //////////////////////////////////////////////////

    always @(posedge aclk) begin
        if (aresetn) begin
            for (int p = 0; p < 2; p++) begin
                // Expected value travels with the address
                if (awvalid[p] && awready[p]) begin
                    b_q[p].push_back(exp_b[p]);
                end
                if (arvalid[p] && arready[p]) begin
                    r_q[p].push_back(exp_r[p]);
                end
                if (bvalid[p] && bready[p]) begin
                    if (b_q[p].size() == 0) begin
                        errors++;
                        $display("Port %0d gave a write response with no write pending", p);
                    end else begin
                        exp_bv = b_q[p].pop_front();
                        compare($sformatf("s%0d_b.resp", p), 32'(exp_bv.resp),
                            32'(b[p].resp));
                    end
                end
                // In-order per port, so the queue head is the match
                if (rvalid[p] && rready[p]) begin
                    if (r_q[p].size() == 0) begin
                        errors++;
                        $display("Port %0d gave a read response with no read pending", p);
                    end else begin
                        exp_rv = r_q[p].pop_front();
                        compare($sformatf("s%0d_r.data", p), exp_rv.data, r[p].data);
                        compare($sformatf("s%0d_r.resp", p), 32'(exp_rv.resp),
                            32'(r[p].resp));
                    end
                end
            end
        end
    end

endmodule

// File: tests/tb_axil_mem.sv
/* Testbench top: DUT, reference memory model, LFSR stimulus, test sequence and timeout */
`timescale 1ns/1ns

module tb_axil_mem;

    import axil_pkg::*;

    localparam int MEM_ADDR_WIDTH = 10;
    localparam int FIFO_ADDR_WIDTH = 2;
    localparam int N_RAND = 24;
    // Directed transactions plus the random ones on both ports
    localparam int N_TXN = 20 + 2 * N_RAND;
    localparam int TIMEOUT_CYCLES = 40 * N_TXN + 200;

    logic                aclk;
    logic                aresetn;
    axil_aw_t [1:0]      aw;
    logic [1:0]          awvalid;
    wire [1:0]           awready;
    axil_w_t [1:0]       w;
    logic [1:0]          wvalid;
    wire [1:0]           wready;
    wire axil_b_t [1:0]  b;
    wire [1:0]           bvalid;
    logic [1:0]          bready;
    axil_ar_t [1:0]      ar;
    logic [1:0]          arvalid;
    wire [1:0]           arready;
    wire axil_r_t [1:0]  r;
    wire [1:0]           rvalid;
    logic [1:0]          rready;
    // Expected responses, set together with each address
    axil_b_t [1:0]       exp_b;
    axil_r_t [1:0]       exp_r;
    int                  chk_errors;
    int                  chk_count;
    int                  tb_errs;
    int                  errs_seen;
    int                  cycles;
    logic [31:0]         lfsr_state;
    logic [31:0]         ref_mem [2**MEM_ADDR_WIDTH];
    // Random traffic, drawn before both ports start
    logic                rnd_wr   [2][N_RAND];
    logic [2:0]          rnd_word [2][N_RAND];
    logic [31:0]         rnd_data [2][N_RAND];
    logic [3:0]          rnd_strb [2][N_RAND];

    tb_clock #(.PERIOD_NS(10), .RESET_CYCLES(16)) u_clock (.aclk, .aresetn);

    axil_mem_top #(
        .MEM_ADDR_WIDTH  (MEM_ADDR_WIDTH),
        .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) UUT (
        .aclk, .aresetn,
        .s0_aw(aw[0]), .s0_awvalid(awvalid[0]), .s0_awready(awready[0]),
        .s0_w(w[0]), .s0_wvalid(wvalid[0]), .s0_wready(wready[0]),
        .s0_b(b[0]), .s0_bvalid(bvalid[0]), .s0_bready(bready[0]),
        .s0_ar(ar[0]), .s0_arvalid(arvalid[0]), .s0_arready(arready[0]),
        .s0_r(r[0]), .s0_rvalid(rvalid[0]), .s0_rready(rready[0]),
        .s1_aw(aw[1]), .s1_awvalid(awvalid[1]), .s1_awready(awready[1]),
        .s1_w(w[1]), .s1_wvalid(wvalid[1]), .s1_wready(wready[1]),
        .s1_b(b[1]), .s1_bvalid(bvalid[1]), .s1_bready(bready[1]),
        .s1_ar(ar[1]), .s1_arvalid(arvalid[1]), .s1_arready(arready[1]),
        .s1_r(r[1]), .s1_rvalid(rvalid[1]), .s1_rready(rready[1])
    );

    axil_mem_checker u_checker (
        .aclk, .aresetn, .awvalid, .awready, .arvalid, .arready,
        .b, .bvalid, .bready, .r, .rvalid, .rready, .exp_b, .exp_r,
        .errors(chk_errors), .checks(chk_count)
    );

    //////////////////////////////////////////////////
    // Reference model and random source
    //////////////////////////////////////////////////

    // Strobe lane i covers bits 8i+7..8i, nonzero bits above the RAM depth are out of range
    function automatic axil_r_t ref_access(input logic wr, input logic [31:0] addr,
            input logic [31:0] wdata, input logic [3:0] strb);
        logic [29:0] word;
        axil_r_t     res;
        word = addr[31:2];
        res = '{data: 32'h0, resp: OKAY};
        if ((word >> MEM_ADDR_WIDTH) != 30'h0) begin
            res.resp = SLVERR;
        end else if (wr) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    ref_mem[word[MEM_ADDR_WIDTH-1:0]][8*i +: 8] = wdata[8*i +: 8];
                end
            end
        end else begin
            res.data = ref_mem[word[MEM_ADDR_WIDTH-1:0]];
        end
        return res;
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic make_random();
        logic [7:0]  seen [2];
        logic [31:0] bits;
        seen[0] = 8'h00;
        seen[1] = 8'h00;
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < N_RAND; i++) begin
                take_bits(1, bits);
                rnd_wr[p][i] = bits[0];
                take_bits(3, bits);
                rnd_word[p][i] = bits[2:0];
                take_bits(32, bits);
                rnd_data[p][i] = bits;
                take_bits(4, bits);
                rnd_strb[p][i] = bits[3:0];
                // First touch of a word writes all of it, reads never see unknown bytes
                if (!seen[p][rnd_word[p][i]]) begin
                    rnd_wr[p][i] = 1'b1;
                    rnd_strb[p][i] = 4'hf;
                end
                if (rnd_wr[p][i]) begin
                    seen[p][rnd_word[p][i]] = 1'b1;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Bus transactions
    //////////////////////////////////////////////////

    task automatic write_txn(input int p, input logic [31:0] addr, input logic [31:0] data,
            input logic [3:0] strb);
        axil_r_t res;
        logic    aw_hs;
        logic    w_hs;
        @(negedge aclk);
        res = ref_access(1'b1, addr, data, strb);
        exp_b[p] = '{resp: res.resp};
        aw[p] = '{addr: addr, prot: 3'b000};
        w[p] = '{data: data, strb: strb};
        awvalid[p] = 1'b1;
        wvalid[p] = 1'b1;
        // AW and W complete independently
        while (awvalid[p] || wvalid[p]) begin
            @(posedge aclk);
            aw_hs = awvalid[p] & awready[p];
            w_hs = wvalid[p] & wready[p];
            @(negedge aclk);
            if (aw_hs) begin
                awvalid[p] = 1'b0;
            end
            if (w_hs) begin
                wvalid[p] = 1'b0;
            end
        end
        @(posedge aclk);
        while (!(bvalid[p] && bready[p])) begin
            @(posedge aclk);
        end
        @(negedge aclk);
    endtask

    task automatic read_issue(input int p, input logic [31:0] addr);
        @(negedge aclk);
        exp_r[p] = ref_access(1'b0, addr, 32'h0, 4'h0);
        ar[p] = '{addr: addr, prot: 3'b000};
        arvalid[p] = 1'b1;
        @(posedge aclk);
        while (!arready[p]) begin
            @(posedge aclk);
        end
        @(negedge aclk);
        arvalid[p] = 1'b0;
    endtask

    task automatic read_txn(input int p, input logic [31:0] addr);
        read_issue(p, addr);
        @(posedge aclk);
        while (!(rvalid[p] && rready[p])) begin
            @(posedge aclk);
        end
        @(negedge aclk);
    endtask

    // Port p owns words 0x100*(p+1) up to +7
    task automatic rand_run(input int p);
        logic [31:0] addr;
        for (int i = 0; i < N_RAND; i++) begin
            addr = 32'(((p + 1) * 256 + int'(rnd_word[p][i])) * 4);
            if (rnd_wr[p][i]) begin
                write_txn(p, addr, rnd_data[p][i], rnd_strb[p][i]);
            end else begin
                read_txn(p, addr);
            end
        end
    endtask

    task automatic end_test(input int num, input string name);
        int total;
        total = tb_errs + chk_errors;
        if (total == errs_seen) begin
            $display("Test %0d %s: passed", num, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", num, name, total - errs_seen);
        end
        errs_seen = total;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] t5_addr [4];
        int          got;
        int          waited;
        aw = '0;
        awvalid = '0;
        w = '0;
        wvalid = '0;
        bready = 2'b11;
        ar = '0;
        arvalid = '0;
        rready = 2'b11;
        exp_b = '0;
        exp_r = '0;
        lfsr_state = 32'he04a;
        t5_addr = '{32'h10, 32'h20, 32'h40, 32'h14};
        @(posedge aresetn);

        write_txn(0, 32'h10, 32'hcafe_0123, 4'hf);
        read_txn(0, 32'h10);
        end_test(1, "write then read on port 0");

        write_txn(1, 32'h20, 32'h5a5a_a5a5, 4'hf);
        read_txn(0, 32'h20);
        end_test(2, "write on port 1, read on port 0");

        write_txn(0, 32'h40, 32'h1122_3344, 4'hf);
        write_txn(0, 32'h40, 32'haabb_ccdd, 4'b0101);
        write_txn(1, 32'h40, 32'h5566_7788, 4'b1000);
        read_txn(0, 32'h40);
        end_test(3, "partial byte strobes");

        // 0x1014 aliases word 5 in its low bits
        write_txn(0, 32'h14, 32'h0bad_f00d, 4'hf);
        write_txn(1, 32'h0000_1014, 32'hffff_ffff, 4'hf);
        read_txn(1, 32'h0000_1014);
        read_txn(0, 32'h14);
        end_test(4, "out-of-range address");

        // Stalled master, R and AR FIFOs fill and the last reads wait for room
        @(negedge aclk);
        rready[0] = 1'b0;
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    read_issue(0, t5_addr[i % 4]);
                end
            end
            begin
                waited = 0;
                @(posedge aclk);
                while (arready[0] && waited < 40) begin
                    @(posedge aclk);
                    waited++;
                end
                if (arready[0]) begin
                    tb_errs++;
                    $display("arready on port 0 stayed high while rready was held low");
                end
                @(negedge aclk);
                rready[0] = 1'b1;
                got = 0;
                while (got < 8) begin
                    @(posedge aclk);
                    if (rvalid[0] && rready[0]) begin
                        got++;
                    end
                end
            end
        join
        @(negedge aclk);
        end_test(5, "read back-pressure");

        make_random();
        fork
            rand_run(0);
            rand_run(1);
        join
        end_test(6, "random traffic on both ports");

        $display("Responses checked: %0d, errors: %0d", chk_count, tb_errs + chk_errors);
        if (tb_errs + chk_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Run limit
    always @(posedge aclk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout, run did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

// File: axil_mem.f
common/axil_pkg.sv
common/mem_pkg.sv
src/ram.sv
src/scfifo.sv
axil_port/axil_port.sv
src/mem_arbiter.sv
src/axil_mem_top.sv
tests/tb_clock.sv
tests/axil_mem_checker.sv
tests/tb_axil_mem.sv

// File: Makefile
# Verilator build and run of the dual-port AXI4-Lite memory testbench
VERILATOR  ?= verilator
TOP        := tb_axil_mem
RTL_TOP    := axil_mem_top
FILELIST   := axil_mem.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
